//--- Bender.yml
package:
  name: rv_core

sources:
  - logic/rvPkg.sv
  - logic/rvDecoder.sv
  - logic/rvRegFile.sv
  - logic/rvAlu.sv
  - logic/rvLsu.sv
  - logic/rvCore.sv
  - target: test
    files:
      - bench/rvCore_asserts.sv
      - bench/rvCoreTb.sv

//--- bench/rvCoreTb.sv
`timescale 1ns/1ps

module rvCoreTb import rvPkg::*; ();
	localparam int cycleLimit = 3000;
	localparam rvWord doneAdr = 32'h100;

	logic clk = 1'b0;
	logic arstN = 1'b0;
	rvWord pc;
	rvWord inst;
	logic halted;
	logic cyc;
	logic stb;
	logic we;
	rvWord adr;
	rvWord datW;
	byteSel sel;
	rvWord datR = '0;
	logic ack = 1'b0;

	rvWord rom [64];
	rvWord mem [128];
	int progLen;
	int waitCnt = 0;
	int maxWait = 0;
	int seed = 32'h112d;
	int cycles = 0;
	int errors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	logic doneSeen = 1'b0;
	rvWord recAdr[$];
	rvWord recDat[$];
	rvWord expAdr[$];
	rvWord expDat[$];
	byteSel recSel[$];
	byteSel expSel[$];

	rvCore #(.resetVector(32'h0)) dut_i (
		.clk(clk), .arstN(arstN), .pc(pc), .inst(inst), .halted(halted),
		.wbCyc(cyc), .wbStb(stb), .wbWe(we), .wbAdr(adr), .wbDatW(datW),
		.wbSel(sel), .wbDatR(datR), .wbAck(ack)
	);

	always #5 clk = ~clk;

	assign inst = rom[pc[7:2]];

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("run stopped after %0d cycles without finishing", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// wishbone slave acks after waitCnt idle cycles
	always @(posedge clk) begin
		if (!arstN) begin
			ack <= 1'b0;
			doneSeen <= 1'b0;
			waitCnt <= 0;
		end else if (ack) begin
			ack <= 1'b0;
			waitCnt <= $unsigned($random(seed)) % (maxWait + 1);
		end else if (cyc && stb) begin
			if (waitCnt != 0) begin
				waitCnt <= waitCnt - 1;
			end else begin
				ack <= 1'b1;
				datR <= mem[adr[8:2]];
				if (we && adr == doneAdr) begin
					doneSeen <= 1'b1;
				end else if (we) begin
					for (int k = 0; k < 4; k++) begin
						if (sel[k]) mem[adr[8:2]][8*k +: 8] <= datW[8*k +: 8];
					end
					recAdr.push_back(adr);
					recSel.push_back(sel);
					recDat.push_back(datW & {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}});
				end
			end
		end
	end

	function automatic rvWord rInst(rvOpcode opc, logic [6:0] f7, logic [2:0] f3,
			logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic rvWord iInst(rvOpcode opc, logic [2:0] f3, logic [4:0] rd,
			logic [4:0] rs1, rvWord imm);
		return {imm[11:0], rs1, f3, rd, opc};
	endfunction

	function automatic rvWord sInst(logic [2:0] f3, logic [4:0] rs2, rvWord imm);
		return {imm[11:5], rs2, 5'd0, f3, imm[4:0], opStore};
	endfunction

	function automatic rvWord bInst(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2, rvWord imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic rvWord uInst(rvOpcode opc, logic [4:0] rd, logic [19:0] upper);
		return {upper, rd, opc};
	endfunction

	function automatic rvWord jInst(logic [4:0] rd, rvWord imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
	endfunction

	task automatic put(input rvWord w);
		rom[progLen] = w;
		progLen++;
	endtask

	// empty rom reads as ebreak
	task automatic newProgram();
		for (int i = 0; i < 64; i++) rom[i] = iInst(opSystem, 3'd0, 5'd0, 5'd0, 32'd1);
		for (int i = 0; i < 128; i++) mem[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_0000;
		progLen = 0;
		expAdr.delete();
		expSel.delete();
		expDat.delete();
	endtask

	task automatic expectStore(input rvWord a, input byteSel s, input rvWord d);
		expAdr.push_back(a);
		expSel.push_back(s);
		expDat.push_back(d);
	endtask

	task automatic resetAndRun();
		@(posedge clk);
		arstN <= 1'b0;
		recAdr.delete();
		recSel.delete();
		recDat.delete();
		repeat (10) @(posedge clk);
		arstN <= 1'b1;
		@(posedge clk);
		while (!doneSeen) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic checkWord(input string name, input rvWord exp, input rvWord act);
		if (exp !== act) begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic checkSel(input string name, input byteSel exp, input byteSel act);
		if (exp !== act) begin
			errors++;
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			errors++;
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic compareRecords(input string name);
		checkWord({name, " store count"}, expAdr.size(), recAdr.size());
		for (int i = 0; i < expAdr.size() && i < recAdr.size(); i++) begin
			checkWord({name, " address"}, expAdr[i], recAdr[i]);
			checkSel({name, " select"}, expSel[i], recSel[i]);
			checkWord({name, " data"}, expDat[i], recDat[i]);
		end
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		testsRun++;
		if (errors == errorsBefore) begin
			$display("%s: ok", name);
		end else begin
			testsFailed++;
			$display("%s: %0d errors", name, errors - errorsBefore);
		end
	endtask

	task automatic arithmeticOps();
		rvWord a = 32'hffff_fffb;
		rvWord b = 32'h1234_5678;
		rvWord exp [22];
		int e0 = errors;
		newProgram();
		put(iInst(opOpImm, 3'd0, 5'd1, 5'd0, -5));
		put(uInst(opLui, 5'd2, 20'h12345));
		put(iInst(opOpImm, 3'd0, 5'd2, 5'd2, 32'h678));
		put(uInst(opAuipc, 5'd3, 20'h1));
		put(rInst(opOp, 7'h00, 3'd0, 5'd4, 5'd1, 5'd2));
		put(rInst(opOp, 7'h20, 3'd0, 5'd5, 5'd2, 5'd1));
		put(iInst(opOpImm, 3'd1, 5'd6, 5'd2, 32'd4));
		put(iInst(opOpImm, 3'd5, 5'd7, 5'd1, 32'h402));
		put(iInst(opOpImm, 3'd5, 5'd8, 5'd1, 32'd28));
		put(rInst(opOp, 7'h00, 3'd4, 5'd9, 5'd1, 5'd2));
		put(rInst(opOp, 7'h00, 3'd2, 5'd10, 5'd1, 5'd2));
		put(rInst(opOp, 7'h00, 3'd3, 5'd11, 5'd1, 5'd2));
		put(rInst(opOp, 7'h00, 3'd6, 5'd12, 5'd1, 5'd2));
		put(rInst(opOp, 7'h00, 3'd7, 5'd13, 5'd1, 5'd2));
		put(rInst(opOp, 7'h20, 3'd5, 5'd14, 5'd1, 5'd8));
		put(rInst(opOp, 7'h00, 3'd5, 5'd15, 5'd2, 5'd8));
		put(rInst(opOp, 7'h00, 3'd1, 5'd16, 5'd2, 5'd8));
		put(iInst(opOpImm, 3'd2, 5'd17, 5'd1, -4));
		put(iInst(opOpImm, 3'd3, 5'd18, 5'd1, -4));
		put(iInst(opOpImm, 3'd4, 5'd19, 5'd2, -1));
		put(iInst(opOpImm, 3'd7, 5'd20, 5'd2, 32'hf0));
		put(iInst(opOpImm, 3'd6, 5'd21, 5'd1, 32'd7));
		exp[1] = a;
		exp[2] = b;
		exp[3] = 32'h1000 + 32'd12;
		exp[4] = a + b;
		exp[5] = b - a;
		exp[6] = b << 4;
		exp[7] = $signed(a) >>> 2;
		exp[8] = a >> 28;
		exp[9] = a ^ b;
		exp[10] = $signed(a) < $signed(b);
		exp[11] = a < b;
		exp[12] = a | b;
		exp[13] = a & b;
		exp[14] = $signed(a) >>> 15;
		exp[15] = b >> 15;
		exp[16] = b << 15;
		exp[17] = $signed(a) < -4;
		exp[18] = a < 32'hffff_fffc;
		exp[19] = ~b;
		exp[20] = b & 32'hf0;
		exp[21] = a | 32'd7;
		for (int k = 1; k < 22; k++) begin
			put(sInst(3'd2, k[4:0], 4 * k));
			expectStore(4 * k, 4'hf, exp[k]);
		end
		put(sInst(3'd2, 5'd0, doneAdr));
		resetAndRun();
		compareRecords("arith");
		finishTest("arith", e0);
	endtask

	function automatic logic branchTaken(logic [2:0] f3, rvWord a, rvWord b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic controlFlow();
		logic [2:0] f3s [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		logic [4:0] r1 [3] = '{5'd1, 5'd2, 5'd2};
		logic [4:0] r2 [3] = '{5'd2, 5'd1, 5'd2};
		rvWord val [3] = '{32'hffff_ffff, 32'd1, 32'd1};
		rvWord val2 [3] = '{32'd1, 32'hffff_ffff, 32'd1};
		int i;
		int j;
		int e0 = errors;
		newProgram();
		put(iInst(opOpImm, 3'd0, 5'd1, 5'd0, -1));
		put(iInst(opOpImm, 3'd0, 5'd2, 5'd0, 32'd1));
		put(iInst(opOpImm, 3'd0, 5'd5, 5'd0, 32'h55));
		for (int p = 0; p < 3; p++) begin
			for (int q = 0; q < 6; q++) begin
				i = p * 6 + q;
				put(bInst(f3s[q], r1[p], r2[p], 32'd8));
				put(sInst(3'd2, 5'd5, 4 * i));
				if (!branchTaken(f3s[q], val[p], val2[p])) expectStore(4 * i, 4'hf, 32'h55);
			end
		end
		// jal skips one marker and links into x6
		j = progLen;
		put(jInst(5'd6, 32'd8));
		put(sInst(3'd2, 5'd5, 32'h80));
		put(sInst(3'd2, 5'd6, 32'h84));
		expectStore(32'h84, 4'hf, (j + 1) * 4);
		j = progLen;
		put(iInst(opOpImm, 3'd0, 5'd7, 5'd0, (j + 3) * 4 + 1));
		put(iInst(opJalr, 3'd0, 5'd8, 5'd7, 32'd0));
		put(sInst(3'd2, 5'd5, 32'h88));
		put(sInst(3'd2, 5'd8, 32'h8c));
		expectStore(32'h8c, 4'hf, (j + 2) * 4);
		put(sInst(3'd2, 5'd0, doneAdr));
		resetAndRun();
		compareRecords("control");
		finishTest("control", e0);
	endtask

	task automatic loadSubword();
		logic [7:0] bv = 8'h80;
		logic [15:0] hv = 16'h8000;
		newProgram();
		put(iInst(opOpImm, 3'd0, 5'd1, 5'd0, 32'h80));
		put(uInst(opLui, 5'd2, 20'h8));
		for (int k = 0; k < 4; k++) begin
			put(sInst(3'd0, 5'd1, 32'h40 + k));
			expectStore(32'h40, 4'b0001 << k, 32'h80 << (8 * k));
		end
		put(sInst(3'd1, 5'd2, 32'h50));
		put(sInst(3'd1, 5'd2, 32'h52));
		expectStore(32'h50, 4'b0011, 32'h0000_8000);
		expectStore(32'h50, 4'b1100, 32'h8000_0000);
		put(iInst(opLoad, 3'd0, 5'd3, 5'd0, 32'h41));
		put(iInst(opLoad, 3'd4, 5'd4, 5'd0, 32'h43));
		put(iInst(opLoad, 3'd1, 5'd5, 5'd0, 32'h52));
		put(iInst(opLoad, 3'd5, 5'd6, 5'd0, 32'h50));
		put(iInst(opLoad, 3'd2, 5'd7, 5'd0, 32'h40));
		for (int k = 3; k < 8; k++) put(sInst(3'd2, k[4:0], 32'h60 + 4 * (k - 3)));
		expectStore(32'h60, 4'hf, {{24{bv[7]}}, bv});
		expectStore(32'h64, 4'hf, {24'd0, bv});
		expectStore(32'h68, 4'hf, {{16{hv[15]}}, hv});
		expectStore(32'h6c, 4'hf, {16'd0, hv});
		expectStore(32'h70, 4'hf, {4{bv}});
		put(sInst(3'd2, 5'd0, doneAdr));
	endtask

	task automatic subwordAccess();
		int e0 = errors;
		maxWait = 0;
		loadSubword();
		resetAndRun();
		compareRecords("subword");
		finishTest("subword", e0);
	endtask

	task automatic waitStateRerun();
		int e0 = errors;
		maxWait = 7;
		loadSubword();
		resetAndRun();
		compareRecords("wait states");
		maxWait = 0;
		finishTest("wait states", e0);
	endtask

	task automatic ebreakHalt();
		int e0 = errors;
		newProgram();
		put(iInst(opOpImm, 3'd0, 5'd1, 5'd0, 32'd1));
		put(iInst(opSystem, 3'd0, 5'd0, 5'd0, 32'd1));
		put(sInst(3'd2, 5'd1, doneAdr));
		@(posedge clk);
		arstN <= 1'b0;
		recAdr.delete();
		repeat (10) @(posedge clk);
		arstN <= 1'b1;
		while (!halted) @(posedge clk);
		for (int n = 0; n < 20; n++) begin
			@(negedge clk);
			checkFlag("ebreak halted", 1'b1, halted);
			checkWord("ebreak pc", 32'd4, pc);
			checkFlag("ebreak bus idle", 1'b0, cyc);
		end
		checkWord("ebreak store count", 32'd0, recAdr.size());
		finishTest("ebreak", e0);
	endtask

	initial begin
		newProgram();
		arithmeticOps();
		controlFlow();
		subwordAccess();
		waitStateRerun();
		ebreakHalt();
		if (dut_i.asserts_i.failCount != 0) begin
			errors++;
			$display("%0d bus or halt assertions failed", dut_i.asserts_i.failCount);
		end
		$display("%0d tests run, %0d failed, %0d check errors", testsRun, testsFailed, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- bench/rvCore_asserts.sv
`timescale 1ns/1ps

module rvCoreAsserts import rvPkg::*; (
	input logic clk,
	input logic arstN,
	input rvWord pc,
	input logic halted,
	input logic cyc,
	input logic stb,
	input logic we,
	input rvWord adr,
	input rvWord datW,
	input byteSel sel,
	input logic ack
);
	int failCount = 0;

	// cyc and stb drop in the cycle after ack
	dropAfterAck: assert property (@(posedge clk) disable iff (!arstN) ack |=> !cyc)
		else begin
			$error("wbCyc still high in the cycle after ack");
			failCount++;
		end

	// master holds the request until ack
	holdUntilAck: assert property (@(posedge clk) disable iff (!arstN)
		stb && !ack |=> stb && $stable(adr) && $stable(we) && $stable(datW) && $stable(sel))
		else begin
			$error("master outputs changed before ack");
			failCount++;
		end

	pcStable: assert property (@(posedge clk) disable iff (!arstN)
		(cyc && !ack) || halted |=> $stable(pc))
		else begin
			$error("pc moved during a pending access or after halt");
			failCount++;
		end

	noBusWhenHalted: assert property (@(posedge clk) disable iff (!arstN) halted |-> !cyc)
		else begin
			$error("wbCyc high while halted");
			failCount++;
		end

endmodule

bind rvCore rvCoreAsserts asserts_i (
	.clk(clk), .arstN(arstN), .pc(pc), .halted(halted), .cyc(wbCyc), .stb(wbStb),
	.we(wbWe), .adr(wbAdr), .datW(wbDatW), .sel(wbSel), .ack(wbAck)
);

//--- logic/rvAlu.sv
`timescale 1ns/1ps

module rvAlu import rvPkg::*; (
	input rvWord a,
	input rvWord b,
	input aluOp op,
	output rvWord result,
	output logic zero
);
	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluSll: result = a << shamt;
			aluSlt: result = {31'b0, $signed(a) < $signed(b)};
			aluSltu: result = {31'b0, a < b};
			aluXor: result = a ^ b;
			aluSrl: result = a >> shamt;
			aluSra: result = rvWord'($signed(a) >>> shamt);
			aluOr: result = a | b;
			aluAnd: result = a & b;
			aluPassB: result = b;
			default: result = '0;
		endcase
	end

	// branch compare uses this
	assign zero = result == '0;

endmodule

//--- logic/rvCore.sv
`timescale 1ns/1ps

module rvCore import rvPkg::*; #(
	parameter rvWord resetVector = '0
) (
	input logic clk,
	input logic arstN,
	output rvWord pc,
	input rvWord inst,
	output logic halted,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output rvWord wbAdr,
	output rvWord wbDatW,
	output byteSel wbSel,
	input rvWord wbDatR,
	input logic wbAck
);
	aluOp aluSel;
	logic aluSrcImm;
	logic regWrite;
	logic memRead;
	logic memWrite;
	memSize size;
	logic loadUnsigned;
	logic branch;
	logic branchOnZero;
	logic jump;
	logic jumpReg;
	rvPkg::wbSel wbSource;
	logic isEbreak;
	rvRegAddr rs1;
	rvRegAddr rs2;
	rvRegAddr rd;
	rvWord imm;

	rvWord readData1;
	rvWord readData2;
	rvWord aluB;
	rvWord aluResult;
	logic zero;
	rvWord loadData;
	logic memDone;

	logic running;
	logic active;
	logic isMem;
	logic advance;
	logic taken;
	rvWord pcPlus4;
	rvWord pcTarget;
	rvWord nextPc;
	rvWord rdData;

	assign active = running & ~halted;
	assign isMem = memRead | memWrite;
	// memory ops retire on ack, ebreak never retires
	assign advance = active & ~isEbreak & (~isMem | memDone);

	assign taken = branch & (branchOnZero ? zero : ~zero);
	assign pcPlus4 = pc + 32'd4;
	assign pcTarget = pc + imm;

	always_comb begin
		if (jumpReg) begin
			nextPc = {aluResult[31:1], 1'b0};
		end else if (jump || taken) begin
			nextPc = pcTarget;
		end else begin
			nextPc = pcPlus4;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			running <= 1'b0;
			halted <= 1'b0;
			pc <= resetVector;
		end else begin
			running <= 1'b1;
			if (active && isEbreak) begin
				halted <= 1'b1;
			end
			if (advance) begin
				pc <= nextPc;
			end
		end
	end

	assign aluB = aluSrcImm ? imm : readData2;

	always_comb begin
		case (wbSource)
			wbLoad: rdData = loadData;
			wbPcPlus4: rdData = pcPlus4;
			wbPcTarget: rdData = pcTarget;
			default: rdData = aluResult;
		endcase
	end

	rvDecoder decoder_i (
		.inst(inst),
		.aluSel(aluSel),
		.aluSrcImm(aluSrcImm),
		.regWrite(regWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.size(size),
		.loadUnsigned(loadUnsigned),
		.branch(branch),
		.branchOnZero(branchOnZero),
		.jump(jump),
		.jumpReg(jumpReg),
		.wbSource(wbSource),
		.isEbreak(isEbreak),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.imm(imm)
	);

	rvRegFile regFile_i (
		.clk(clk),
		.arstN(arstN),
		.writeEnable(regWrite & advance),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.writeData(rdData),
		.readData1(readData1),
		.readData2(readData2)
	);

	rvAlu alu_i (
		.a(readData1),
		.b(aluB),
		.op(aluSel),
		.result(aluResult),
		.zero(zero)
	);

	rvLsu lsu_i (
		.clk(clk),
		.arstN(arstN),
		.request(active & isMem),
		.write(memWrite),
		.loadUnsigned(loadUnsigned),
		.size(size),
		.address(aluResult),
		.storeData(readData2),
		.loadData(loadData),
		.memDone(memDone),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbSel(wbSel),
		.wbDatR(wbDatR),
		.wbAck(wbAck)
	);

endmodule

//--- logic/rvDecoder.sv
`timescale 1ns/1ps

module rvDecoder import rvPkg::*; (
	input rvWord inst,
	output aluOp aluSel,
	output logic aluSrcImm,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output memSize size,
	output logic loadUnsigned,
	output logic branch,
	output logic branchOnZero,
	output logic jump,
	output logic jumpReg,
	output wbSel wbSource,
	output logic isEbreak,
	output rvRegAddr rs1,
	output rvRegAddr rs2,
	output rvRegAddr rd,
	output rvWord imm
);
	rvOpcode opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	rvWord iImm;
	rvWord sImm;
	rvWord bImm;
	rvWord uImm;
	rvWord jImm;

	// shared by OP and OP-IMM, alt selects sub or sra
	function automatic aluOp aluFromFunct(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: aluFromFunct = alt ? aluSub : aluAdd;
			3'b001: aluFromFunct = aluSll;
			3'b010: aluFromFunct = aluSlt;
			3'b011: aluFromFunct = aluSltu;
			3'b100: aluFromFunct = aluXor;
			3'b101: aluFromFunct = alt ? aluSra : aluSrl;
			3'b110: aluFromFunct = aluOr;
			default: aluFromFunct = aluAnd;
		endcase
	endfunction

	assign opcode = rvOpcode'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];
	assign rd = inst[11:7];

	assign iImm = {{20{inst[31]}}, inst[31:20]};
	assign sImm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign bImm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign uImm = {inst[31:12], 12'b0};
	assign jImm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		aluSel = aluAdd;
		aluSrcImm = 1'b0;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		size = sizeWord;
		loadUnsigned = 1'b0;
		branch = 1'b0;
		branchOnZero = 1'b0;
		jump = 1'b0;
		jumpReg = 1'b0;
		wbSource = wbAlu;
		isEbreak = 1'b0;
		imm = '0;
		case (opcode)
			opLui: begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				aluSel = aluPassB;
				imm = uImm;
			end
			opAuipc: begin
				regWrite = 1'b1;
				imm = uImm;
				wbSource = wbPcTarget;
			end
			opJal: begin
				regWrite = 1'b1;
				jump = 1'b1;
				imm = jImm;
				wbSource = wbPcPlus4;
			end
			opJalr: begin
				if (funct3 == 3'b000) begin
					regWrite = 1'b1;
					jumpReg = 1'b1;
					aluSrcImm = 1'b1;
					imm = iImm;
					wbSource = wbPcPlus4;
				end
			end
			opBranch: begin
				imm = bImm;
				// eq and ge conditions are taken on a zero result
				branch = funct3 != 3'b010 && funct3 != 3'b011;
				branchOnZero = funct3 == f3Beq || funct3 == f3Bge || funct3 == f3Bgeu;
				if (funct3 == f3Beq || funct3 == f3Bne) begin
					aluSel = aluSub;
				end else if (funct3 == f3Blt || funct3 == f3Bge) begin
					aluSel = aluSlt;
				end else begin
					aluSel = aluSltu;
				end
			end
			opLoad: begin
				if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
					regWrite = 1'b1;
					memRead = 1'b1;
					aluSrcImm = 1'b1;
					imm = iImm;
					wbSource = wbLoad;
					size = memSize'(funct3[1:0]);
					loadUnsigned = funct3[2];
				end
			end
			opStore: begin
				if (funct3[2] == 1'b0 && funct3[1:0] != 2'b11) begin
					memWrite = 1'b1;
					aluSrcImm = 1'b1;
					imm = sImm;
					size = memSize'(funct3[1:0]);
				end
			end
			opOpImm: begin
				aluSrcImm = 1'b1;
				imm = iImm;
				aluSel = aluFromFunct(funct3, funct3 == 3'b101 && inst[30]);
				if (funct3 == 3'b001) begin
					regWrite = funct7 == funct7Base;
				end else if (funct3 == 3'b101) begin
					regWrite = funct7 == funct7Base || funct7 == funct7Alt;
				end else begin
					regWrite = 1'b1;
				end
			end
			opOp: begin
				aluSel = aluFromFunct(funct3, inst[30]);
				regWrite = funct7 == funct7Base ||
					(funct7 == funct7Alt && (funct3 == 3'b000 || funct3 == 3'b101));
			end
			opSystem: begin
				isEbreak = inst == ebreakInst;
			end
			default: begin
			end
		endcase
	end

endmodule

//--- logic/rvLsu.sv
`timescale 1ns/1ps

module rvLsu import rvPkg::*; (
	input logic clk,
	input logic arstN,
	input logic request,
	input logic write,
	input logic loadUnsigned,
	input memSize size,
	input rvWord address,
	input rvWord storeData,
	output rvWord loadData,
	output logic memDone,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output rvWord wbAdr,
	output rvWord wbDatW,
	output byteSel wbSel,
	input rvWord wbDatR,
	input logic wbAck
);
	logic doneQ;
	logic [1:0] offset;
	rvWord byteLane;
	rvWord halfLane;

	assign offset = address[1:0];

	// idle one cycle after ack so the same request is not reissued
	assign wbCyc = request & ~doneQ;
	assign wbStb = wbCyc;
	assign wbWe = wbCyc & write;
	assign wbAdr = {address[31:2], 2'b00};
	assign memDone = wbCyc & wbAck;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			doneQ <= 1'b0;
		end else begin
			doneQ <= memDone;
		end
	end

	// lane select and store replication
	always_comb begin
		case (size)
			sizeByte: begin
				wbSel = byteSel'(4'b0001 << offset);
				wbDatW = {4{storeData[7:0]}};
			end
			sizeHalf: begin
				wbSel = offset[1] ? 4'b1100 : 4'b0011;
				wbDatW = {2{storeData[15:0]}};
			end
			default: begin
				wbSel = 4'b1111;
				wbDatW = storeData;
			end
		endcase
	end

	assign byteLane = wbDatR >> {offset, 3'b000};
	assign halfLane = wbDatR >> {offset[1], 4'b0000};

	always_comb begin
		case (size)
			sizeByte: loadData = {{24{byteLane[7] & ~loadUnsigned}}, byteLane[7:0]};
			sizeHalf: loadData = {{16{halfLane[15] & ~loadUnsigned}}, halfLane[15:0]};
			default: loadData = wbDatR;
		endcase
	end

endmodule

//--- logic/rvPkg.sv
package rvPkg;

	typedef logic [31:0] rvWord;
	typedef logic [4:0] rvRegAddr;
	typedef logic [3:0] byteSel;

	// major opcodes, bits [6:0] of the instruction
	typedef enum logic [6:0] {
		opLui = 7'b0110111,
		opAuipc = 7'b0010111,
		opJal = 7'b1101111,
		opJalr = 7'b1100111,
		opBranch = 7'b1100011,
		opLoad = 7'b0000011,
		opStore = 7'b0100011,
		opOpImm = 7'b0010011,
		opOp = 7'b0110011,
		opSystem = 7'b1110011
	} rvOpcode;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd,
		aluPassB
	} aluOp;

	typedef enum logic [1:0] {
		sizeByte,
		sizeHalf,
		sizeWord
	} memSize;

	// writeback source for rd
	typedef enum logic [1:0] {
		wbAlu,
		wbLoad,
		wbPcPlus4,
		wbPcTarget
	} wbSel;

	// the only SYSTEM encoding the core recognizes
	localparam rvWord ebreakInst = 32'h0010_0073;

	localparam logic [6:0] funct7Base = 7'b0000000;
	localparam logic [6:0] funct7Alt = 7'b0100000;

	localparam logic [2:0] f3Beq = 3'b000;
	localparam logic [2:0] f3Bne = 3'b001;
	localparam logic [2:0] f3Blt = 3'b100;
	localparam logic [2:0] f3Bge = 3'b101;
	localparam logic [2:0] f3Bltu = 3'b110;
	localparam logic [2:0] f3Bgeu = 3'b111;

endpackage

//--- logic/rvRegFile.sv
`timescale 1ns/1ps

module rvRegFile import rvPkg::*; (
	input logic clk,
	input logic arstN,
	input logic writeEnable,
	input rvRegAddr rs1,
	input rvRegAddr rs2,
	input rvRegAddr rd,
	input rvWord writeData,
	output rvWord readData1,
	output rvWord readData2
);
	rvWord regs [32];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && rd != '0) begin
			regs[rd] <= writeData;
		end
	end

	assign readData1 = regs[rs1];
	assign readData2 = regs[rs2];

endmodule

//--- vlog.f
logic/rvPkg.sv
logic/rvDecoder.sv
logic/rvRegFile.sv
logic/rvAlu.sv
logic/rvLsu.sv
logic/rvCore.sv
bench/rvCore_asserts.sv
bench/rvCoreTb.sv
